// File: Makefile
TOOL       := verilator
TOP        := tb_dcache
FILELIST   := filelist.f
FLAGS      := --binary --timing --assert -Wno-fatal --top-module $(TOP)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR) -o sim_$(TOP)
	./$(OBJ_DIR)/sim_$(TOP) 2>&1 | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: addr_decode.sv
`default_nettype none

`include "cache_macros.svh"

module addr_decode (
    input  mem_bus_pkg::cpu_req_t  req,
    output cache_pkg::tag_t        tag,
    output cache_pkg::index_t      index,
    output cache_pkg::word_sel_t   word_sel,
    output mem_bus_pkg::addr_t     phys_addr,
    output logic                   uncached
);
    import mem_bus_pkg::*;

    logic [3:0] seg;
    logic [3:0] phys_seg;
    addr_t      folded;

    assign seg = req.addr[31:28];

    always_comb begin
        case (seg)
            `DC_SEG_KERNEL0, `DC_SEG_UNCACHED0: phys_seg = 4'h0;
            `DC_SEG_KERNEL1, `DC_SEG_UNCACHED1: phys_seg = 4'h1;
            default:                            phys_seg = seg;    // user and kseg2/3
        endcase
    end

    assign uncached  = (seg == `DC_SEG_UNCACHED0) || (seg == `DC_SEG_UNCACHED1);
    assign folded    = {phys_seg, req.addr[27:0]};
    assign phys_addr = folded;

    // byte offset dropped
    assign {tag, index, word_sel} = folded[31:2];

endmodule

`default_nettype wire

// File: cache_ctrl.sv
`default_nettype none

module cache_ctrl (
    input  logic                  clk,
    input  logic                  resetn,
    input  mem_bus_pkg::cpu_req_t req,
    input  logic                  uncached,
    input  mem_bus_pkg::addr_t    phys_addr,
    input  cache_pkg::tag_t       tag,
    input  cache_pkg::index_t     index,
    input  cache_pkg::word_sel_t  word_sel,
    input  cache_pkg::lookup_t    lookup,
    output mem_bus_pkg::cpu_resp_t resp,
    output mem_bus_pkg::mem_req_t  mem_req,
    input  mem_bus_pkg::mem_resp_t mem_resp,
    output cache_pkg::way_mask_t  way_write,
    output cache_pkg::way_fill_t  fill,
    output logic                  touch,
    output cache_pkg::way_id_t    touch_way,
    output cache_pkg::index_t     touch_index
);
    import mem_bus_pkg::*;
    import cache_pkg::*;

    ctrl_state_t state_q, state_d;
    word_sel_t   beat_q;
    cpu_req_t    req_q;
    addr_t       paddr_q;
    tag_t        tag_q;
    tag_t        wb_tag_q;
    index_t      index_q;
    word_sel_t   word_q;
    way_id_t     victim_q;
    line_t       line_q;       // victim on write-back, refill buffer after
    word_t       data_q;
    line_t       merged;
    line_t       refill_line;
    logic        beat_done;

    assign beat_done = mem_resp.ready && mem_resp.last;

    always_comb begin
        merged = lookup.hit_line;
        for (int b = 0; b < 4; b++) begin
            if (req_q.strobe[b]) merged[word_q][8*b +: 8] = req_q.data[8*b +: 8];
        end
    end

    always_comb begin
        refill_line         = line_q;
        refill_line[beat_q] = mem_resp.data;    // final beat goes straight in
    end

    always_comb begin
        state_d     = state_q;
        mem_req     = '0;
        way_write   = '0;
        fill.line   = merged;
        fill.tag    = tag_q;
        fill.dirty  = 1'b1;
        touch       = 1'b0;
        touch_way   = lookup.hit_way;
        touch_index = index_q;
        case (state_q)
            IDLE: begin
                if (req.valid) state_d = uncached ? UNCACHED : LOOKUP;
            end
            LOOKUP: begin
                if (lookup.hit) begin
                    touch = 1'b1;
                    if (|req_q.strobe) way_write = way_mask_t'(1'b1) << lookup.hit_way;
                    state_d = RESPOND;
                end else if (lookup.victim_meta.valid && lookup.victim_meta.dirty) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL;
                end
            end
            WRITEBACK: begin
                mem_req.valid    = 1'b1;
                mem_req.is_write = 1'b1;
                mem_req.addr     = {wb_tag_q, index_q, 4'b0000};
                mem_req.strobe   = 4'hf;
                mem_req.data     = line_q[beat_q];
                mem_req.burst    = 1'b1;
                if (beat_done) state_d = REFILL;
            end
            REFILL: begin
                mem_req.valid = 1'b1;
                mem_req.addr  = {tag_q, index_q, 4'b0000};
                mem_req.burst = 1'b1;
                if (beat_done) begin
                    way_write  = way_mask_t'(1'b1) << victim_q;
                    fill.line  = refill_line;
                    fill.dirty = 1'b0;
                    state_d    = LOOKUP;    // retry, hits now
                end
            end
            UNCACHED: begin
                mem_req.valid    = 1'b1;
                mem_req.is_write = |req_q.strobe;
                mem_req.addr     = paddr_q;
                mem_req.strobe   = req_q.strobe;
                mem_req.data     = req_q.data;
                if (beat_done) state_d = RESPOND;
            end
            RESPOND: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state_q <= IDLE;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            if (mem_req.valid && mem_resp.ready) begin
                beat_q <= mem_resp.last ? '0 : beat_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            IDLE: begin
                if (req.valid) begin
                    req_q      <= req;
                    paddr_q    <= phys_addr;
                    tag_q      <= tag;
                    index_q    <= index;
                    word_q     <= word_sel;
                end
            end
            LOOKUP: begin
                data_q   <= lookup.hit_line[word_q];
                victim_q <= lookup.victim_way;
                wb_tag_q <= lookup.victim_meta.tag;
                line_q   <= lookup.victim_line;
            end
            REFILL: begin
                if (mem_resp.ready) line_q <= refill_line;
            end
            UNCACHED: begin
                if (mem_resp.ready) data_q <= mem_resp.data;
            end
            default: ;
        endcase
    end

    assign resp.data_ok = (state_q == RESPOND);
    assign resp.data    = data_q;

    // memory side holds its request through stalls
    assert property (@(posedge clk) disable iff (resetn)
        mem_req.valid && !mem_resp.ready |=> $stable(mem_req));

    // decode runs off dreq, so it must match the latched copy until data_ok
    assert property (@(posedge clk) disable iff (resetn)
        state_q != IDLE |-> req == req_q);

endmodule

`default_nettype wire

// File: cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// cache geometry
`define DC_WAYS             4
`define DC_SETS             4
`define DC_LINE_WORDS       4
`define DC_TAG_BITS         26

// segment nibbles of the virtual address
`define DC_SEG_UNCACHED0    4'ha
`define DC_SEG_UNCACHED1    4'hb
`define DC_SEG_KERNEL0      4'h8
`define DC_SEG_KERNEL1      4'h9

`endif

// File: cache_pkg.sv
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

    localparam int NUM_WAYS = `DC_WAYS;

    typedef logic [`DC_TAG_BITS-1:0]           tag_t;
    typedef logic [$clog2(`DC_SETS)-1:0]       index_t;
    typedef logic [$clog2(`DC_LINE_WORDS)-1:0] word_sel_t;
    typedef logic [$clog2(`DC_WAYS)-1:0]       way_id_t;
    typedef logic [`DC_WAYS-1:0]               way_mask_t;
    typedef mem_bus_pkg::word_t [`DC_LINE_WORDS-1:0] line_t;
    typedef logic [2:0]                        plru_t;    // tree bits, see way_select

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } way_meta_t;

    typedef struct packed {
        line_t line;
        tag_t  tag;
        logic  dirty;
    } way_fill_t;

    typedef struct packed {
        logic      hit;
        way_id_t   hit_way;
        line_t     hit_line;
        way_id_t   victim_way;
        way_meta_t victim_meta;
        line_t     victim_line;
    } lookup_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        UNCACHED,
        RESPOND
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: cache_way.sv
`default_nettype none

module cache_way (
    input  logic                 clk,
    input  logic                 resetn,
    input  cache_pkg::index_t    index,
    input  cache_pkg::tag_t      tag,
    input  logic                 write_en,
    input  cache_pkg::way_fill_t fill,
    output cache_pkg::way_meta_t meta,
    output cache_pkg::line_t     line,
    output logic                 hit
);
    import cache_pkg::*;

    localparam int SETS = 2 ** $bits(index_t);

    logic [SETS-1:0] valid_q;
    logic [SETS-1:0] dirty_q;
    tag_t            tag_q  [SETS];
    line_t           line_q [SETS];

    // combinational read of the indexed set
    assign meta.valid = valid_q[index];
    assign meta.dirty = dirty_q[index];
    assign meta.tag   = tag_q[index];
    assign line       = line_q[index];

    assign hit = meta.valid && (meta.tag == tag);

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (write_en) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= fill.dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            tag_q[index]  <= fill.tag;
            line_q[index] <= fill.line;    // whole line each time
        end
    end

endmodule

`default_nettype wire

// File: dcache_top.sv
`default_nettype none

module dcache_top (
    input  logic                   clk,
    input  logic                   resetn,
    input  mem_bus_pkg::cpu_req_t  dreq,
    output mem_bus_pkg::cpu_resp_t dresp,
    output mem_bus_pkg::mem_req_t  creq,
    input  mem_bus_pkg::mem_resp_t cresp
);
    import mem_bus_pkg::*;
    import cache_pkg::*;

    addr_t      phys_addr;
    tag_t       tag;
    index_t     index;
    word_sel_t  word_sel;
    logic       uncached;
    way_mask_t  hits;
    way_mask_t  way_write;
    way_meta_t  metas [NUM_WAYS];
    line_t      lines [NUM_WAYS];
    way_fill_t  fill;
    lookup_t    lookup;
    logic       touch;
    way_id_t    touch_way;
    index_t     touch_index;

    // dreq is held by the CPU, so it equals the latched request
    addr_decode u_decode (
        .req       (dreq),
        .tag       (tag),
        .index     (index),
        .word_sel  (word_sel),
        .phys_addr (phys_addr),
        .uncached  (uncached)
    );

    for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
        cache_way u_way (
            .clk      (clk),
            .resetn   (resetn),
            .index    (index),
            .tag      (tag),
            .write_en (way_write[i]),
            .fill     (fill),
            .meta     (metas[i]),
            .line     (lines[i]),
            .hit      (hits[i])
        );
    end

    way_select u_select (
        .clk         (clk),
        .resetn      (resetn),
        .index       (index),
        .hits        (hits),
        .metas       (metas),
        .lines       (lines),
        .touch       (touch),
        .touch_way   (touch_way),
        .touch_index (touch_index),
        .result      (lookup)
    );

    cache_ctrl u_ctrl (
        .clk         (clk),
        .resetn      (resetn),
        .req         (dreq),
        .uncached    (uncached),
        .phys_addr   (phys_addr),
        .tag         (tag),
        .index       (index),
        .word_sel    (word_sel),
        .lookup      (lookup),
        .resp        (dresp),
        .mem_req     (creq),
        .mem_resp    (cresp),
        .way_write   (way_write),
        .fill        (fill),
        .touch       (touch),
        .touch_way   (touch_way),
        .touch_index (touch_index)
    );

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
mem_bus_pkg.sv
cache_pkg.sv
addr_decode.sv
cache_way.sv
way_select.sv
cache_ctrl.sv
dcache_top.sv
tb_mem.sv
tb_dcache.sv

// File: mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  strobe_t;

    typedef struct packed {
        logic    valid;
        addr_t   addr;
        strobe_t strobe;    // all zero on a read
        word_t   data;
    } cpu_req_t;

    typedef struct packed {
        logic  data_ok;     // one cycle pulse
        word_t data;
    } cpu_resp_t;

    typedef struct packed {
        logic    valid;
        logic    is_write;
        addr_t   addr;      // line base on a burst
        strobe_t strobe;
        word_t   data;      // current beat
        logic    burst;     // 1 = four beats
    } mem_req_t;

    typedef struct packed {
        logic  ready;
        logic  last;
        word_t data;
    } mem_resp_t;

endpackage

`default_nettype wire

// File: tb_dcache.sv
`default_nettype none

module tb_dcache;
    import mem_bus_pkg::*;

    localparam int WORDS    = 2048;
    localparam int N_RANDOM = 2000;
    localparam int N_OPS    = 256 + 2 * 64 + 12 + 2 * 8 + N_RANDOM;

    logic      clk;
    logic      resetn;
    cpu_req_t  dreq;
    cpu_resp_t dresp;
    mem_req_t  creq;
    mem_resp_t cresp;
    word_t     shadow [WORDS];
    logic      unc_open;
    mem_req_t  unc_exp;
    int        unc_beats;

    dcache_top dut (
        .clk    (clk),
        .resetn (resetn),
        .dreq   (dreq),
        .dresp  (dresp),
        .creq   (creq),
        .cresp  (cresp)
    );

    tb_mem u_mem (
        .clk  (clk),
        .req  (creq),
        .resp (cresp)
    );

    always #20 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_mem_req(input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH creq got 0x%h expected 0x%h", got, exp));
        end
    endtask

    function automatic word_t merge_bytes(word_t old, word_t data, strobe_t strobe);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    // one CPU access, from request to data_ok
    task automatic access(input addr_t vaddr, input strobe_t strobe, input word_t data);
        int   idx;
        logic unc;
        idx = int'(vaddr[12:2]);    // segments 8 and a both fold to 0
        unc = (vaddr[31:28] == 4'ha);
        if (unc) begin
            unc_exp = '{valid: 1'b1, is_write: |strobe, addr: {4'h0, vaddr[27:0]},
                        strobe: strobe, data: data, burst: 1'b0};
            unc_beats = 0;
            unc_open  = 1'b1;
        end
        dreq = '{valid: 1'b1, addr: vaddr, strobe: strobe, data: data};
        @(negedge clk);
        while (!dresp.data_ok) @(negedge clk);
        if (strobe == '0) begin
            check_word($sformatf("dresp.data at 0x%08h", vaddr), dresp.data, shadow[idx]);
        end else begin
            shadow[idx] = merge_bytes(shadow[idx], data, strobe);
        end
        if (unc && unc_beats != 1) begin
            stop_run($sformatf("uncached access to 0x%08h took %0d beats", vaddr, unc_beats));
        end
        unc_open = 1'b0;
        @(posedge clk);
        #2;
        dreq = '0;
    endtask

    // single beats belong to uncached accesses only
    always @(negedge clk) begin
        if (!resetn && creq.valid && cresp.ready && !creq.burst) begin
            if (!unc_open) begin
                stop_run("single-beat memory request seen outside an uncached access");
            end else begin
                check_mem_req(creq, unc_exp);
                unc_beats++;
            end
        end
    end

    initial begin
        #(N_OPS * 60 * 40 + 10 * 40);
        stop_run("timeout: the DUT stopped answering with data_ok");
    end

    initial begin
        addr_t   a;
        strobe_t s;
        void'($urandom(32'hedac3424));
        clk       = 1'b0;
        resetn    = 1'b1;
        dreq      = '0;
        unc_open  = 1'b0;
        unc_exp   = '0;
        unc_beats = 0;
        for (int i = 0; i < WORDS; i++) begin
            shadow[i] = word_t'(i * 4) ^ 32'h5a5a0000;
        end
        repeat (4) @(posedge clk);
        #2;
        resetn = 1'b0;

        for (int i = 0; i < 256; i++) begin
            access(32'h8000_0000 | addr_t'(i * 4), 4'h0, '0);
        end

        repeat (64) begin
            a = 32'h8000_0000 | addr_t'(($urandom % 256) * 4);
            access(a, strobe_t'($urandom % 15 + 1), $urandom);
            access(a, 4'h0, '0);
        end

        // six tags in one set force dirty evictions
        s = strobe_t'($urandom % 4);
        for (int t = 0; t < 6; t++) begin
            access(32'h8000_0000 | addr_t'(t * 64 + s * 16 + (t % 4) * 4), 4'hf, $urandom);
        end
        for (int t = 0; t < 6; t++) begin
            access(32'h8000_0000 | addr_t'(t * 64 + s * 16 + (t % 4) * 4), 4'h0, '0);
        end

        repeat (8) begin
            a = 32'ha000_1000 | addr_t'(($urandom % 64) * 4);
            access(a, strobe_t'($urandom % 15 + 1), $urandom);
            access(a, 4'h0, '0);
        end

        repeat (N_RANDOM) begin
            if ($urandom % 4 == 0) begin
                a = 32'ha000_1000 | addr_t'(($urandom % 64) * 4);
            end else begin
                a = 32'h8000_0000 | addr_t'(($urandom % 256) * 4);
            end
            if ($urandom % 2 == 0) begin
                access(a, strobe_t'($urandom % 15 + 1), $urandom);
            end else begin
                access(a, 4'h0, '0);
            end
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_mem.sv
`default_nettype none

module tb_mem (
    input  logic                   clk,
    input  mem_bus_pkg::mem_req_t  req,
    output mem_bus_pkg::mem_resp_t resp
);
    import mem_bus_pkg::*;

    localparam int WORDS = 2048;    // physical 0x0000 to 0x1fff

    word_t mem [WORDS];
    int    beat;
    addr_t cur;

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = word_t'(i * 4) ^ 32'h5a5a0000;
        end
        resp = '0;
        beat = 0;
        forever begin
            @(negedge clk);
            // beat taken at the coming edge
            if (req.valid && resp.ready) begin
                cur = req.addr + addr_t'(beat * 4);
                if (req.is_write) begin
                    for (int b = 0; b < 4; b++) begin
                        if (req.strobe[b]) mem[cur[12:2]][8*b +: 8] = req.data[8*b +: 8];
                    end
                end
                beat = resp.last ? 0 : beat + 1;
            end
            @(posedge clk);
            #2;
            cur        = req.addr + addr_t'(beat * 4);
            resp.ready = req.valid && ($urandom % 4 != 0);    // about one stall in four
            resp.last  = req.burst ? (beat == 3) : 1'b1;
            resp.data  = mem[cur[12:2]];
        end
    end

endmodule

`default_nettype wire

// File: way_select.sv
`default_nettype none

module way_select (
    input  logic                 clk,
    input  logic                 resetn,
    input  cache_pkg::index_t    index,
    input  cache_pkg::way_mask_t hits,
    input  cache_pkg::way_meta_t metas [cache_pkg::NUM_WAYS],
    input  cache_pkg::line_t     lines [cache_pkg::NUM_WAYS],
    input  logic                 touch,
    input  cache_pkg::way_id_t   touch_way,
    input  cache_pkg::index_t    touch_index,
    output cache_pkg::lookup_t   result
);
    import cache_pkg::*;

    localparam int SETS = 2 ** $bits(index_t);

    plru_t [SETS-1:0] plru_q;
    plru_t            cur;
    way_id_t          hit_way;
    way_id_t          lru_way;
    way_id_t          victim;

    assign cur = plru_q[index];

    always_comb begin
        hit_way = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (hits[i]) hit_way = way_id_t'(i);
        end
    end

    // bit 0 picks the half, bits 1 and 2 pick within it
    assign lru_way = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};

    always_comb begin
        victim = lru_way;
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            if (!metas[i].valid) victim = way_id_t'(i);    // lowest empty way wins
        end
    end

    assign result.hit         = |hits;
    assign result.hit_way     = hit_way;
    assign result.hit_line    = lines[hit_way];
    assign result.victim_way  = victim;
    assign result.victim_meta = metas[victim];
    assign result.victim_line = lines[victim];

    always_ff @(posedge clk) begin
        if (resetn) begin
            plru_q <= '0;
        end else if (touch) begin
            plru_q[touch_index][0] <= ~touch_way[1];    // point at other half
            if (touch_way[1]) begin
                plru_q[touch_index][2] <= ~touch_way[0];
            end else begin
                plru_q[touch_index][1] <= ~touch_way[0];
            end
        end
    end

    // no tag may sit in two ways of one set
    assert property (@(posedge clk) disable iff (resetn) $onehot0(hits));

endmodule

`default_nettype wire
